/* Makefile */
# Verilator build and run for the VRC6 mapper testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_vrc6
RTL_TOP   ?= vrc6_mapper
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

SOURCES := $(wildcard hw/*.sv hw/*.svh tests/*.sv)

.PHONY: all build run lint clean

all: run

build: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "^TEST OK$$" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* hw/vrc6_audio.sv */
// VRC6 expansion sound, two pulse channels and one saw
// output is the raw sum of the three channel levels, range 0..61

`timescale 1ns/100ps

module vrc6_audio (
    input  logic                  clk20,
    input  logic                  reset,
    input  logic                  ce,
    input  vrc6_pkg::sound_regs_t sound,
    output logic [5:0]            audio_level
);
    logic [3:0] pulse0_level;
    logic [3:0] pulse1_level;
    logic [4:0] saw_level;

    vrc6_pulse pulse0 (
        .clk20 (clk20),
        .reset (reset),
        .ce    (ce),
        .cfg   (sound.pulse[0]),
        .level (pulse0_level)
    );

    vrc6_pulse pulse1 (
        .clk20 (clk20),
        .reset (reset),
        .ce    (ce),
        .cfg   (sound.pulse[1]),
        .level (pulse1_level)
    );

    vrc6_saw saw0 (
        .clk20 (clk20),
        .reset (reset),
        .ce    (ce),
        .cfg   (sound.saw),
        .level (saw_level)
    );

    assign audio_level = {2'b00, pulse0_level} + {2'b00, pulse1_level} + {1'b0, saw_level};

endmodule

/* hw/vrc6_bank_map.sv */
// PRG and CHR bank translation for the VRC6
// purely combinational, follows the live CPU and PPU addresses

`timescale 1ns/100ps

module vrc6_bank_map (
    input  vrc6_pkg::bank_regs_t banks,
    input  logic [15:0]          cpu_addr,
    input  logic [13:0]          chr_addr,
    input  logic [5:0]           cfg_prgmask,
    input  logic [6:0]           cfg_chrmask,
    output logic [5:0]           prg_bank,    // address bits 18:13
    output logic [8:0]           chr_bank,    // address bits 18:10
    output logic                 ciram_ce
);
    logic [5:0] prg_sel;
    logic [7:0] chr_sel;
    logic       mirror_bit;

    always_comb begin
        case (cpu_addr[15:13])
            3'b100, 3'b101: prg_sel = {banks.prg8, cpu_addr[13]};   // 16k window
            3'b110:         prg_sel = banks.prgc;
            3'b111:         prg_sel = '1;   // fixed last bank
            default:        prg_sel = '0;
        endcase
    end

    assign chr_sel = banks.chr[chr_addr[12:10]];

    // nametable select when the PPU is in 2000-3FFF
    always_comb begin
        case (banks.mirror)
            2'd0:    mirror_bit = chr_addr[10];   // vertical
            2'd1:    mirror_bit = chr_addr[11];   // horizontal
            2'd2:    mirror_bit = 1'b0;
            default: mirror_bit = 1'b1;
        endcase
    end

    assign prg_bank = prg_sel & cfg_prgmask;
    assign chr_bank = {{1'b0, chr_sel[7:2]} & cfg_chrmask,
                       chr_sel[1],
                       chr_addr[13] ? mirror_bit : chr_sel[0]};
    assign ciram_ce = chr_addr[13];

endmodule

/* hw/vrc6_irq_counter.sv */
// VRC6 IRQ counter, scanline or cpu cycle mode
// an 8-bit up counter reloads from the latch on overflow and raises the IRQ flag

`timescale 1ns/100ps
`include "vrc6_macros.svh"

module vrc6_irq_counter (
    input  logic                clk20,
    input  logic                reset,
    input  logic                ce,
    input  vrc6_pkg::irq_ctrl_t irq_ctrl,
    output logic                irq
);
    logic [6:0] prescaler;
    logic [1:0] line;       // position in the three line pattern
    logic [7:0] count;
    logic       live_en;
    logic       timeout;
    logic       count_clk;

    // scanline mode ticks once per prescaler wrap
    assign count_clk = irq_ctrl.mode_cycle || (prescaler == '0);

    always_ff @(posedge clk20 or posedge reset) begin
        if (reset) begin
            prescaler <= '0;
            line      <= '0;
            count     <= '0;
            live_en   <= 1'b0;
            timeout   <= 1'b0;
        end else if (irq_ctrl.ctrl_write) begin
            prescaler <= `VRC6_PRESCALE_LONG;
            line      <= '0;
            count     <= irq_ctrl.latch;
            live_en   <= irq_ctrl.enable;
            timeout   <= 1'b0;
        end else if (irq_ctrl.ack_write) begin
            live_en <= irq_ctrl.enable_after_ack;
            timeout <= 1'b0;
        end else if (ce && live_en) begin
            if (prescaler != '0) begin
                prescaler <= prescaler - 1'b1;
            end else begin
                prescaler <= line[1] ? `VRC6_PRESCALE_SHORT : `VRC6_PRESCALE_LONG;
                line      <= line[1] ? 2'd0 : line + 1'b1;
            end
            if (count_clk) begin
                if (count == 8'hff) begin
                    count   <= irq_ctrl.latch;   // overflow, reload and flag
                    timeout <= 1'b1;
                end else begin
                    count <= count + 1'b1;
                end
            end
        end
    end

    assign irq = timeout && live_en;

endmodule

/* hw/vrc6_macros.svh */
// shared constants for the VRC6 mapper
// include wherever bus widths, register pages or IRQ prescaler reloads are needed

`ifndef VRC6_MACROS_SVH
`define VRC6_MACROS_SVH

// CPU bus widths
`define VRC6_ADDR_W 16
`define VRC6_DATA_W 8

// register pages, CPU address bits 15:12
`define VRC6_PAGE_PRG8   4'h8
`define VRC6_PAGE_PULSE1 4'h9
`define VRC6_PAGE_PULSE2 4'hA
`define VRC6_PAGE_SAW    4'hB
`define VRC6_PAGE_PRGC   4'hC
`define VRC6_PAGE_CHR_LO 4'hD
`define VRC6_PAGE_CHR_HI 4'hE
`define VRC6_PAGE_IRQ    4'hF

// scanline prescaler reloads, 113 113 112 approximates 341/3 cpu cycles
`define VRC6_PRESCALE_LONG  7'd113
`define VRC6_PRESCALE_SHORT 7'd112

// saw accumulator steps per period
`define VRC6_SAW_STEPS 7

`endif

/* hw/vrc6_mapper.sv */
// VRC6 cartridge mapper top, mapper 24 or 26 by the mapper26 strap
// connects the register decoder to bank mapping, IRQ and expansion sound

`timescale 1ns/100ps

module vrc6_mapper (
    input  logic              clk20,
    input  logic              reset,
    input  logic              ce,
    input  logic              mapper26,
    input  vrc6_pkg::cpu_wr_t cpu,
    input  logic [13:0]       chr_addr,
    input  logic [5:0]        cfg_prgmask,
    input  logic [6:0]        cfg_chrmask,
    output logic [5:0]        prg_bank,
    output logic [8:0]        chr_bank,
    output logic              ciram_ce,
    output logic              irq,
    output logic [5:0]        audio_level
);
    vrc6_pkg::bank_regs_t  banks;
    vrc6_pkg::irq_ctrl_t   irq_ctrl;
    vrc6_pkg::sound_regs_t sound;

    vrc6_reg_decode decode0 (
        .clk20    (clk20),
        .reset    (reset),
        .ce       (ce),
        .mapper26 (mapper26),
        .cpu      (cpu),
        .banks    (banks),
        .irq_ctrl (irq_ctrl),
        .sound    (sound)
    );

    // bank map sees the unswapped address, only A13..A15 matter there
    vrc6_bank_map map0 (
        .banks       (banks),
        .cpu_addr    (cpu.addr),
        .chr_addr    (chr_addr),
        .cfg_prgmask (cfg_prgmask),
        .cfg_chrmask (cfg_chrmask),
        .prg_bank    (prg_bank),
        .chr_bank    (chr_bank),
        .ciram_ce    (ciram_ce)
    );

    vrc6_irq_counter irq0 (
        .clk20    (clk20),
        .reset    (reset),
        .ce       (ce),
        .irq_ctrl (irq_ctrl),
        .irq      (irq)
    );

    vrc6_audio audio0 (
        .clk20       (clk20),
        .reset       (reset),
        .ce          (ce),
        .sound       (sound),
        .audio_level (audio_level)
    );

endmodule

/* hw/vrc6_period_divider.sv */
// programmable period divider for the sound channels
// steps once every period+1 enabled ce cycles

`timescale 1ns/100ps

module vrc6_period_divider #(
    parameter type period_t = logic [11:0]
) (
    input  logic    clk20,
    input  logic    reset,
    input  logic    ce,
    input  logic    en,
    input  period_t period,
    output logic    step
);
    period_t count;

    assign step = ce && en && (count == '0);

    always_ff @(posedge clk20 or posedge reset) begin
        if (reset) begin
            count <= '0;
        end else if (ce && en) begin
            if (count == '0)
                count <= period;   // reload on terminal count
            else
                count <= count - 1'b1;
        end
    end

endmodule

/* hw/vrc6_pkg.sv */
// struct types shared by the VRC6 mapper RTL and its testbench
// register state travels between blocks in these packed structs

`include "vrc6_macros.svh"

package vrc6_pkg;

    // one CPU bus beat
    typedef struct packed {
        logic [`VRC6_ADDR_W-1:0] addr;
        logic [`VRC6_DATA_W-1:0] data;
        logic                    we;
    } cpu_wr_t;

    typedef struct packed {
        logic [4:0]      prg8;
        logic [5:0]      prgc;
        logic [7:0][7:0] chr;    // 1k CHR banks 0..7
        logic [1:0]      mirror;
    } bank_regs_t;

    typedef struct packed {
        logic [7:0] latch;
        logic       mode_cycle;
        logic       enable;
        logic       enable_after_ack;
        logic       ctrl_write;       // one cycle after Fxx1 write
        logic       ack_write;        // one cycle after Fxx2 write
    } irq_ctrl_t;

    typedef logic [11:0] pulse_period_t;
    typedef logic [12:0] saw_period_t;

    typedef struct packed {
        logic          mode;   // constant volume when set
        logic [2:0]    duty;
        logic [3:0]    vol;
        pulse_period_t period;
        logic          en;
    } pulse_cfg_t;

    typedef struct packed {
        logic [5:0]  rate;
        logic [11:0] period;
        logic        en;
    } saw_cfg_t;

    typedef struct packed {
        pulse_cfg_t [1:0] pulse;
        saw_cfg_t         saw;
    } sound_regs_t;

endpackage

/* hw/vrc6_pulse.sv */
// one VRC6 pulse channel
// 16-step duty sequencer, or constant volume when mode is set

`timescale 1ns/100ps

module vrc6_pulse (
    input  logic                 clk20,
    input  logic                 reset,
    input  logic                 ce,
    input  vrc6_pkg::pulse_cfg_t cfg,
    output logic [3:0]           level
);
    import vrc6_pkg::*;

    logic       step;
    logic [3:0] step_cnt;

    vrc6_period_divider #(.period_t(pulse_period_t)) div0 (
        .clk20  (clk20),
        .reset  (reset),
        .ce     (ce),
        .en     (cfg.en),
        .period (cfg.period),
        .step   (step)
    );

    always_ff @(posedge clk20 or posedge reset) begin
        if (reset) begin
            step_cnt <= '0;
            level    <= '0;
        end else begin
            if (step)
                step_cnt <= step_cnt + 1'b1;
            // high for steps 0..duty of each 16
            if (cfg.en && (cfg.mode || step_cnt <= {1'b0, cfg.duty}))
                level <= cfg.vol;
            else
                level <= '0;
        end
    end

endmodule

/* hw/vrc6_reg_decode.sv */
// CPU write decoder for the VRC6 register file
// turns qualified bus writes into bank, IRQ and sound register structs

`timescale 1ns/100ps
`include "vrc6_macros.svh"

module vrc6_reg_decode (
    input  logic                  clk20,
    input  logic                  reset,
    input  logic                  ce,
    input  logic                  mapper26,
    input  vrc6_pkg::cpu_wr_t     cpu,
    output vrc6_pkg::bank_regs_t  banks,
    output vrc6_pkg::irq_ctrl_t   irq_ctrl,
    output vrc6_pkg::sound_regs_t sound
);
    import vrc6_pkg::*;

    cpu_wr_t    bus;        // bus with mapper 26 line swap applied
    logic [3:0] page;
    logic [1:0] sel;
    logic       pulse_idx;

    // mapper 26 board swaps A0 and A1
    assign bus.addr = mapper26 ? {cpu.addr[`VRC6_ADDR_W-1:2], cpu.addr[0], cpu.addr[1]}
                               : cpu.addr;
    assign bus.data = cpu.data;
    assign bus.we   = cpu.we;

    assign page      = bus.addr[15:12];
    assign sel       = bus.addr[1:0];
    assign pulse_idx = (page == `VRC6_PAGE_PULSE2);

    always_ff @(posedge clk20 or posedge reset) begin
        if (reset) begin
            banks    <= '0;
            irq_ctrl <= '0;
            sound    <= '0;
        end else begin
            irq_ctrl.ctrl_write <= 1'b0;   // strobes last one cycle
            irq_ctrl.ack_write  <= 1'b0;
            if (ce && bus.we) begin
                case (page)
                    `VRC6_PAGE_PRG8:   banks.prg8 <= bus.data[4:0];
                    `VRC6_PAGE_PRGC:   banks.prgc <= bus.data[5:0];
                    `VRC6_PAGE_CHR_LO: banks.chr[{1'b0, sel}] <= bus.data;
                    `VRC6_PAGE_CHR_HI: banks.chr[{1'b1, sel}] <= bus.data;
                    `VRC6_PAGE_PULSE1, `VRC6_PAGE_PULSE2: begin
                        case (sel)
                            2'd0: begin
                                sound.pulse[pulse_idx].mode <= bus.data[7];
                                sound.pulse[pulse_idx].duty <= bus.data[6:4];
                                sound.pulse[pulse_idx].vol  <= bus.data[3:0];
                            end
                            2'd1: sound.pulse[pulse_idx].period[7:0] <= bus.data;
                            2'd2: begin
                                sound.pulse[pulse_idx].en           <= bus.data[7];
                                sound.pulse[pulse_idx].period[11:8] <= bus.data[3:0];
                            end
                            default: ;
                        endcase
                    end
                    `VRC6_PAGE_SAW: begin
                        case (sel)
                            2'd0: sound.saw.rate <= bus.data[5:0];
                            2'd1: sound.saw.period[7:0] <= bus.data;
                            2'd2: begin
                                sound.saw.en           <= bus.data[7];
                                sound.saw.period[11:8] <= bus.data[3:0];
                            end
                            default: banks.mirror <= bus.data[3:2];   // B003
                        endcase
                    end
                    `VRC6_PAGE_IRQ: begin
                        case (sel)
                            2'd0: irq_ctrl.latch <= bus.data;
                            2'd1: begin
                                irq_ctrl.mode_cycle       <= bus.data[2];
                                irq_ctrl.enable           <= bus.data[1];
                                irq_ctrl.enable_after_ack <= bus.data[0];
                                irq_ctrl.ctrl_write       <= 1'b1;
                            end
                            2'd2: irq_ctrl.ack_write <= 1'b1;
                            default: ;
                        endcase
                    end
                    default: ;   // below 8000, nothing to latch
                endcase
            end
        end
    end

endmodule

/* hw/vrc6_saw.sv */
// VRC6 sawtooth channel
// accumulator adds rate six times, then clears on the seventh step

`timescale 1ns/100ps
`include "vrc6_macros.svh"

module vrc6_saw (
    input  logic               clk20,
    input  logic               reset,
    input  logic               ce,
    input  vrc6_pkg::saw_cfg_t cfg,
    output logic [4:0]         level
);
    import vrc6_pkg::*;

    saw_period_t saw_period;
    logic        step;
    logic [2:0]  step_idx;
    logic [7:0]  acc;

    // saw runs at half the register rate
    assign saw_period = {cfg.period, 1'b1};

    vrc6_period_divider #(.period_t(saw_period_t)) div0 (
        .clk20  (clk20),
        .reset  (reset),
        .ce     (ce),
        .en     (cfg.en),
        .period (saw_period),
        .step   (step)
    );

    always_ff @(posedge clk20 or posedge reset) begin
        if (reset) begin
            step_idx <= '0;
            acc      <= '0;
            level    <= '0;
        end else begin
            if (step) begin
                if (step_idx == 3'(`VRC6_SAW_STEPS - 1)) begin
                    step_idx <= '0;
                    acc      <= '0;
                end else begin
                    step_idx <= step_idx + 1'b1;
                    acc      <= acc + {2'b00, cfg.rate};
                end
            end
            level <= cfg.en ? acc[7:3] : '0;   // top five bits only
        end
    end

endmodule

/* src.f */
+incdir+hw
hw/vrc6_pkg.sv
hw/vrc6_period_divider.sv
hw/vrc6_bank_map.sv
hw/vrc6_reg_decode.sv
hw/vrc6_irq_counter.sv
hw/vrc6_pulse.sv
hw/vrc6_saw.sv
hw/vrc6_audio.sv
hw/vrc6_mapper.sv
tests/tb_vrc6.sv

/* tests/tb_vrc6.sv */
// testbench for the VRC6 mapper top level
// covers bank mapping in both address variants, pulse and saw sound, and the IRQ counter
// run through the Makefile, the log is searched for the pass line

`timescale 1ns/100ps
`include "vrc6_macros.svh"

module tb_vrc6;
    import vrc6_pkg::*;

    localparam int CLK_PERIOD      = 100;
    localparam int BANK_SAMPLES    = 40;
    localparam int WATCHDOG_CYCLES = 2000;   // whole run is about 650 cycles
    localparam int IRQ_LIMIT       = 400;

    logic       clk20;
    logic       reset;
    logic       ce;
    logic       mapper26;
    cpu_wr_t    cpu;
    logic [13:0] chr_addr;
    logic [5:0] cfg_prgmask;
    logic [6:0] cfg_chrmask;
    logic [5:0] prg_bank;
    logic [8:0] chr_bank;
    logic       ciram_ce;
    logic       irq;
    logic [5:0] audio_level;

    integer     seed;
    int         errors;
    logic       saw_phase;   // saw alone drives the output

    // register state as the testbench expects it
    logic [4:0] model_prg8;
    logic [5:0] model_prgc;
    logic [7:0] model_chr [8];
    logic [1:0] model_mirror;

    vrc6_mapper dut0 (
        .clk20       (clk20),
        .reset       (reset),
        .ce          (ce),
        .mapper26    (mapper26),
        .cpu         (cpu),
        .chr_addr    (chr_addr),
        .cfg_prgmask (cfg_prgmask),
        .cfg_chrmask (cfg_chrmask),
        .prg_bank    (prg_bank),
        .chr_bank    (chr_bank),
        .ciram_ce    (ciram_ce),
        .irq         (irq),
        .audio_level (audio_level)
    );

    initial begin
        clk20 = 1'b0;
        forever #(CLK_PERIOD / 2) clk20 = ~clk20;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles, the tests did not finish", WATCHDOG_CYCLES);
        $display("TEST FAILED");
        $fatal(1, "timeout");
    end

    task automatic report_mismatch(input string msg);
        errors++;
        $display("Mismatch at time %0t: %s", $time, msg);
        $display("TEST FAILED");
        $fatal(1, "check failed");
    endtask

    // nametable chip enable is PPU A13 in every cycle
    ciram_follows_a13: assert property (@(posedge clk20) disable iff (reset)
        ciram_ce == chr_addr[13])
        else report_mismatch("ciram_ce does not follow chr_addr bit 13");

    saw_in_range: assert property (@(posedge clk20) disable iff (reset)
        !saw_phase || audio_level <= 6'd6)
        else report_mismatch("saw level above 6");

    // one bus beat, returns right after the edge that commits it
    task automatic cpu_write(input logic [15:0] addr, input logic [7:0] data);
        @(posedge clk20);
        cpu.addr <= addr;
        cpu.data <= data;
        cpu.we   <= 1'b1;
        @(posedge clk20);
        cpu.we   <= 1'b0;
    endtask

    // mapper 26 boards exchange A0 and A1
    function automatic logic [1:0] line_swap(input logic [1:0] sel, input logic m26);
        return m26 ? {sel[0], sel[1]} : sel;
    endfunction

    function automatic logic [5:0] expected_prg(input logic [15:0] a, input logic [5:0] mask);
        logic [5:0] bank;
        if (a < 16'h8000)
            bank = 6'd0;
        else if (a < 16'hC000)
            bank = {model_prg8, a[13]};
        else if (a < 16'hE000)
            bank = model_prgc;
        else
            bank = 6'h3f;
        return bank & mask;
    endfunction

    function automatic logic [8:0] expected_chr(input logic [13:0] a, input logic [6:0] mask);
        logic [7:0] bank;
        logic       low_bit;
        bank = model_chr[a[12:10]];
        if (!a[13])
            low_bit = bank[0];
        else if (model_mirror == 2'd0)
            low_bit = a[10];
        else if (model_mirror == 2'd1)
            low_bit = a[11];
        else
            low_bit = model_mirror[0];   // 2 gives 0, 3 gives 1
        return {{1'b0, bank[7:2]} & mask, bank[1], low_bit};
    endfunction

    task automatic run_bank_test(input logic m26);
        logic [31:0] rnd;
        logic [1:0]  sel;
        @(posedge clk20);
        mapper26 <= m26;
        rnd = $random(seed);
        cpu_write(16'h8000, rnd[7:0]);
        model_prg8 = rnd[4:0];
        rnd = $random(seed);
        cpu_write(16'hC000, rnd[7:0]);
        model_prgc = rnd[5:0];
        for (int i = 0; i < 8; i++) begin
            rnd = $random(seed);
            sel = line_swap(i[1:0], m26);
            cpu_write({(i < 4) ? 4'hD : 4'hE, 10'h000, sel}, rnd[7:0]);
            model_chr[i] = rnd[7:0];
        end
        rnd = $random(seed);
        cpu_write(16'hB003, rnd[7:0]);
        model_mirror = rnd[3:2];
        repeat (BANK_SAMPLES) begin
            @(posedge clk20);
            rnd = $random(seed);
            cpu.addr <= rnd[15:0];
            chr_addr <= rnd[29:16];
            rnd = $random(seed);
            cfg_prgmask <= rnd[5:0];
            cfg_chrmask <= rnd[12:6];
            @(negedge clk20);
            assert (prg_bank == expected_prg(cpu.addr, cfg_prgmask))
                else report_mismatch($sformatf("prg_bank %h for cpu addr %h, mapper26 %b",
                                               prg_bank, cpu.addr, m26));
            assert (chr_bank == expected_chr(chr_addr, cfg_chrmask))
                else report_mismatch($sformatf("chr_bank %h for chr addr %h, mapper26 %b",
                                               chr_bank, chr_addr, m26));
        end
    endtask

    // level register lags the decoder by one edge
    task automatic expect_level(input logic [5:0] exp, input string what);
        @(posedge clk20);
        @(negedge clk20);
        assert (audio_level == exp)
            else report_mismatch($sformatf("%s: audio_level %0d, expected %0d",
                                           what, audio_level, exp));
    endtask

    // edges from the control write until irq is seen high
    task automatic wait_for_irq(output int edges);
        edges = 0;
        do begin
            @(posedge clk20);
            edges++;
            @(negedge clk20);
        end while (!irq && edges < IRQ_LIMIT);
    endtask

    // one edge for the control strobe, then 256-latch counter ticks
    function automatic int expected_irq_edges(input int latch, input logic scanline);
        if (scanline)
            return 1 + (256 - latch) * (`VRC6_PRESCALE_LONG + 1);
        return 1 + (256 - latch);
    endfunction

    initial begin
        int         edges;
        int         high_cycles;
        logic [6:0] seen;
        seed        = 32'h63bb;
        errors      = 0;
        saw_phase   = 1'b0;
        reset       = 1'b1;
        ce          = 1'b1;
        mapper26    = 1'b0;
        cpu         = '0;
        chr_addr    = '0;
        cfg_prgmask = '1;
        cfg_chrmask = '1;
        repeat (2) @(posedge clk20);
        reset <= 1'b0;

        @(negedge clk20);
        assert (!irq && audio_level == 6'd0)
            else report_mismatch("irq or audio_level not cleared by reset");

        run_bank_test(1'b0);
        run_bank_test(1'b1);
        @(posedge clk20);
        mapper26 <= 1'b0;

        // pulse channels in constant volume mode
        cpu_write(16'h9000, 8'h89);
        cpu_write(16'h9002, 8'h80);
        expect_level(6'd9, "pulse 1 constant");
        cpu_write(16'hA000, 8'h85);
        cpu_write(16'hA002, 8'h80);
        expect_level(6'd14, "both pulses constant");

        // duty 3 of 16 steps, two cycles per step
        cpu_write(16'hA002, 8'h00);
        cpu_write(16'h9000, 8'h31);
        cpu_write(16'h9001, 8'h01);
        cpu_write(16'h9002, 8'h80);
        repeat (4) @(posedge clk20);
        high_cycles = 0;
        repeat (32) begin
            @(negedge clk20);
            if (audio_level == 6'd1)
                high_cycles++;
        end
        assert (high_cycles == 8)
            else report_mismatch($sformatf("pulse duty high for %0d of 32 cycles", high_cycles));

        // saw alone, rate 8, accumulator tops out at 48
        cpu_write(16'h9002, 8'h00);
        cpu_write(16'hB000, 8'h08);
        cpu_write(16'hB001, 8'h00);
        cpu_write(16'hB002, 8'h80);
        repeat (2) @(posedge clk20);
        saw_phase <= 1'b1;
        seen = '0;
        repeat (28) begin
            @(negedge clk20);
            if (audio_level <= 6'd6)
                seen[audio_level[2:0]] = 1'b1;
        end
        assert (seen == 7'h7f)
            else report_mismatch($sformatf("saw levels seen %b, expected all of 0..6", seen));
        @(posedge clk20);
        saw_phase <= 1'b0;
        cpu_write(16'hB002, 8'h00);

        // IRQ in cycle mode
        cpu_write(16'hF000, 8'd250);
        cpu_write(16'hF001, 8'h06);
        wait_for_irq(edges);
        assert (edges == expected_irq_edges(250, 1'b0))
            else report_mismatch($sformatf("cycle mode irq after %0d edges, expected %0d",
                                           edges, expected_irq_edges(250, 1'b0)));
        cpu_write(16'hF002, 8'h00);
        @(posedge clk20);   // ack strobe reaches the counter one edge after the write
        repeat (20) begin
            @(negedge clk20);
            assert (!irq) else report_mismatch("irq high after acknowledge");
        end

        // IRQ in scanline mode
        cpu_write(16'hF000, 8'd254);
        cpu_write(16'hF001, 8'h02);
        wait_for_irq(edges);
        assert (edges == expected_irq_edges(254, 1'b1))
            else report_mismatch($sformatf("scanline irq after %0d edges, expected %0d",
                                           edges, expected_irq_edges(254, 1'b1)));

        repeat (2) @(posedge clk20);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule
